// ==== verilog/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// word and datapath widths
`define INSTR_WIDTH      32
`define DATA_WIDTH       64
`define REG_COUNT        16
`define REG_IDX_WIDTH    4
`define OPER_WIDTH       4
`define GROUP_WIDTH      3

// common fields
`define GROUP_MSB        31
`define GROUP_LSB        29
`define RA_MSB           28
`define RA_LSB           25
`define OP_TYPE_BIT      12
`define SIMM12_MSB       11
`define SIMM12_LSB       0

// groups 0, 2 and 3
`define RB_MSB           24
`define RB_LSB           21
`define RC_MSB           20
`define RC_LSB           17
`define OPER_MSB         16
`define OPER_LSB         13

// group 1 puts oper where rb lives
`define CTRL_OPER_MSB    24
`define CTRL_OPER_LSB    21
`define SIMM20_MSB       20
`define SIMM20_LSB       1

// busy lengths
`define EX_STALL_CYCLES  2
`define WB_STALL_CYCLES  3

`endif

// ==== verilog/decode_pkg.sv ====
`include "decode_cfg.svh"

package decode_pkg;

	// top three bits of the word
	typedef enum logic [`GROUP_WIDTH-1:0]
	{
		alu_grp   = 3'd0,
		ctrl_grp  = 3'd1,
		load_grp  = 3'd2,
		store_grp = 3'd3
	} instr_group_e;

	// group 0 operations
	typedef enum logic [`OPER_WIDTH-1:0]
	{
		add     = 4'd0,
		sub     = 4'd1,
		slt     = 4'd2,
		mul     = 4'd3,
		div     = 4'd4,
		and_op  = 4'd5,
		orr     = 4'd6,
		xor_op  = 4'd7,
		shl     = 4'd8,
		shr     = 4'd9,
		inv     = 4'd10,
		addi    = 4'd11,
		subi    = 4'd12,
		cpy     = 4'd13,
		ipc     = 4'd14,
		bad_alu = 4'd15
	} alu_op_e;

	// group 1 operations, the rest are reserved
	typedef enum logic [`OPER_WIDTH-1:0]
	{
		btru = 4'd0,
		bfal = 4'd1,
		jmp  = 4'd2
	} ctrl_op_e;

	// loads and stores, 9 to 15 reserved
	typedef enum logic [`OPER_WIDTH-1:0]
	{
		u8  = 4'd0,
		s8  = 4'd1,
		u16 = 4'd2,
		s16 = 4'd3,
		u32 = 4'd4,
		s32 = 4'd5,
		u64 = 4'd6,
		s64 = 4'd7,
		f16 = 4'd8
	} mem_op_e;

	// where a later instruction has to wait until
	typedef enum logic [1:0]
	{
		stall_none       = 2'd0,
		stall_ends_in_ex = 2'd1,
		stall_ends_in_wb = 2'd2
	} stall_class_e;

endpackage

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ps

`include "decode_cfg.svh"

module instr_decoder
	import decode_pkg::*;
(
	input  logic [`INSTR_WIDTH-1:0]   instr,
	output instr_group_e              group,
	output logic [`OPER_WIDTH-1:0]    oper,
	output logic                      op_type,
	output logic [`REG_IDX_WIDTH-1:0] ra_index,
	output logic [`REG_IDX_WIDTH-1:0] rb_index,
	output logic [`REG_IDX_WIDTH-1:0] rc_index,
	output logic [`DATA_WIDTH-1:0]    imm,
	output logic                      nop,
	output logic                      force64,
	output stall_class_e              stall_class
);

	localparam int SIMM12_WIDTH = `SIMM12_MSB - `SIMM12_LSB + 1;
	localparam int SIMM20_WIDTH = `SIMM20_MSB - `SIMM20_LSB + 1;

	logic [SIMM12_WIDTH-1:0] simm12;
	logic [SIMM20_WIDTH-1:0] simm20;
	logic [`DATA_WIDTH-1:0]  simm12_ext;
	logic [`DATA_WIDTH-1:0]  simm20_ext;
	alu_op_e                 alu_op;
	ctrl_op_e                ctrl_op;
	mem_op_e                 mem_op;

	// fields shared by every group
	assign group    = instr_group_e'(instr[`GROUP_MSB:`GROUP_LSB]);
	assign op_type  = instr[`OP_TYPE_BIT];
	assign ra_index = instr[`RA_MSB:`RA_LSB];
	assign rb_index = instr[`RB_MSB:`RB_LSB];
	assign rc_index = instr[`RC_MSB:`RC_LSB];

	// oper sits in a different place for group 1
	assign alu_op  = alu_op_e'(instr[`OPER_MSB:`OPER_LSB]);
	assign mem_op  = mem_op_e'(instr[`OPER_MSB:`OPER_LSB]);
	assign ctrl_op = ctrl_op_e'(instr[`CTRL_OPER_MSB:`CTRL_OPER_LSB]);

	assign simm12 = instr[`SIMM12_MSB:`SIMM12_LSB];
	assign simm20 = instr[`SIMM20_MSB:`SIMM20_LSB];

	assign simm12_ext = {{(`DATA_WIDTH - SIMM12_WIDTH){simm12[SIMM12_WIDTH-1]}}, simm12};
	assign simm20_ext = {{(`DATA_WIDTH - SIMM20_WIDTH){simm20[SIMM20_WIDTH-1]}}, simm20};

	// only the wide integer ops, nop does not matter here
	assign force64 = (group == alu_grp)
		&& ((alu_op == div) || (alu_op == shl)
		|| (alu_op == shr) || (alu_op == inv));

	always_comb
	begin
		case (group)
			alu_grp:
			begin
				oper        = alu_op;
				nop         = (alu_op == bad_alu);
				imm         = simm12_ext;
				stall_class = stall_none;
			end

			ctrl_grp:
			begin
				oper        = ctrl_op;
				nop         = !((ctrl_op == btru) || (ctrl_op == bfal)
					|| (ctrl_op == jmp));
				imm         = simm20_ext;
				stall_class = stall_ends_in_ex;
			end

			load_grp, store_grp:
			begin
				oper = mem_op;
				// upper half is reserved apart from f16
				nop         = (mem_op != f16) && mem_op[3];
				imm         = simm12_ext;
				stall_class = stall_ends_in_wb;
			end

			// groups 4 to 7 are not defined yet
			default:
			begin
				oper        = '0;
				nop         = 1'b1;
				imm         = '0;
				stall_class = stall_none;
			end
		endcase
	end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

`include "decode_cfg.svh"

module reg_file
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      wr_en,
	input  logic [`REG_IDX_WIDTH-1:0] wr_index,
	input  logic [`DATA_WIDTH-1:0]    wr_data,
	input  logic [`REG_IDX_WIDTH-1:0] ra_index,
	input  logic [`REG_IDX_WIDTH-1:0] rb_index,
	input  logic [`REG_IDX_WIDTH-1:0] rc_index,
	output logic [`DATA_WIDTH-1:0]    ra_data,
	output logic [`DATA_WIDTH-1:0]    rb_data,
	output logic [`DATA_WIDTH-1:0]    rc_data
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			regs[wr_index] <= wr_data;
		end
	end

	// write-through so a same-cycle read sees the new value
	always_comb
	begin
		ra_data = regs[ra_index];
		rb_data = regs[rb_index];
		rc_data = regs[rc_index];

		if (wr_en && (wr_index == ra_index))
		begin
			ra_data = wr_data;
		end
		if (wr_en && (wr_index == rb_index))
		begin
			rb_data = wr_data;
		end
		if (wr_en && (wr_index == rc_index))
		begin
			rc_data = wr_data;
		end
	end

endmodule

// ==== verilog/stall_unit.sv ====
`timescale 1ns/1ps

`include "decode_cfg.svh"

module stall_unit
	import decode_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         accept,
	input  logic         nop,
	input  stall_class_e stall_class,
	output logic         busy
);

	// wide enough for the longest stall
	localparam int CNT_WIDTH = $clog2(`WB_STALL_CYCLES + 1);

	logic [CNT_WIDTH-1:0] count;
	logic [CNT_WIDTH-1:0] stall_len;
	logic                 start;

	always_comb
	begin
		case (stall_class)
			stall_ends_in_ex:
			begin
				stall_len = CNT_WIDTH'(`EX_STALL_CYCLES);
			end
			stall_ends_in_wb:
			begin
				stall_len = CNT_WIDTH'(`WB_STALL_CYCLES);
			end
			default:
			begin
				stall_len = '0;
			end
		endcase
	end

	// nops never hold the pipe
	assign start = accept && !nop && (stall_class != stall_none);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count <= '0;
		end
		else if (start)
		begin
			count <= stall_len;
		end
		else if (count != '0)
		begin
			count <= count - 1'b1;
		end
	end

	assign busy = (count != '0);

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

`include "decode_cfg.svh"

module decode_stage
	import decode_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      instr_valid,
	input  logic [`INSTR_WIDTH-1:0]   instr,
	input  logic                      wr_en,
	input  logic [`REG_IDX_WIDTH-1:0] wr_index,
	input  logic [`DATA_WIDTH-1:0]    wr_data,
	output logic                      busy,
	output logic                      out_valid,
	output instr_group_e              out_group,
	output logic [`OPER_WIDTH-1:0]    out_oper,
	output logic                      out_op_type,
	output logic [`REG_IDX_WIDTH-1:0] out_ra_index,
	output logic [`REG_IDX_WIDTH-1:0] out_rb_index,
	output logic [`REG_IDX_WIDTH-1:0] out_rc_index,
	output logic [`DATA_WIDTH-1:0]    out_ra_data,
	output logic [`DATA_WIDTH-1:0]    out_rb_data,
	output logic [`DATA_WIDTH-1:0]    out_rc_data,
	output logic [`DATA_WIDTH-1:0]    out_imm,
	output logic                      out_nop,
	output logic                      out_force64,
	output stall_class_e              out_stall_class
);

	instr_group_e              group;
	logic [`OPER_WIDTH-1:0]    oper;
	logic                      op_type;
	logic [`REG_IDX_WIDTH-1:0] ra_index;
	logic [`REG_IDX_WIDTH-1:0] rb_index;
	logic [`REG_IDX_WIDTH-1:0] rc_index;
	logic [`DATA_WIDTH-1:0]    imm;
	logic                      nop;
	logic                      force64;
	stall_class_e              stall_class;
	logic [`DATA_WIDTH-1:0]    ra_data;
	logic [`DATA_WIDTH-1:0]    rb_data;
	logic [`DATA_WIDTH-1:0]    rc_data;
	logic                      accept;

	instr_decoder u_decoder
	(
		.instr       (instr),
		.group       (group),
		.oper        (oper),
		.op_type     (op_type),
		.ra_index    (ra_index),
		.rb_index    (rb_index),
		.rc_index    (rc_index),
		.imm         (imm),
		.nop         (nop),
		.force64     (force64),
		.stall_class (stall_class)
	);

	reg_file u_reg_file
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_data  (wr_data),
		.ra_index (ra_index),
		.rb_index (rb_index),
		.rc_index (rc_index),
		.ra_data  (ra_data),
		.rb_data  (rb_data),
		.rc_data  (rc_data)
	);

	// strobes during a stall are dropped
	assign accept = instr_valid && !busy;

	stall_unit u_stall_unit
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.accept      (accept),
		.nop         (nop),
		.stall_class (stall_class),
		.busy        (busy)
	);

	// one pulse per accepted word
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= accept;
		end
	end

	// hold the last accepted instruction for execute
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_group       <= alu_grp;
			out_oper        <= '0;
			out_op_type     <= 1'b0;
			out_ra_index    <= '0;
			out_rb_index    <= '0;
			out_rc_index    <= '0;
			out_ra_data     <= '0;
			out_rb_data     <= '0;
			out_rc_data     <= '0;
			out_imm         <= '0;
			out_nop         <= 1'b0;
			out_force64     <= 1'b0;
			out_stall_class <= stall_none;
		end
		else if (accept)
		begin
			out_group       <= group;
			out_oper        <= oper;
			out_op_type     <= op_type;
			out_ra_index    <= ra_index;
			out_rb_index    <= rb_index;
			out_rc_index    <= rc_index;
			out_ra_data     <= ra_data;
			out_rb_data     <= rb_data;
			out_rc_data     <= rc_data;
			out_imm         <= imm;
			out_nop         <= nop;
			out_force64     <= force64;
			out_stall_class <= stall_class;
		end
	end

endmodule

// ==== tests/decode_stage_assertions.sv ====
`timescale 1ns/1ps

`include "decode_cfg.svh"

module decode_stage_assertions
	import decode_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input logic busy,
	input logic out_valid
);

	int failures;

	initial
	begin
		failures = 0;
	end

	// no back to back pulses with one instruction in flight
	assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
		else
		begin
			$error("out_valid high in two consecutive cycles");
			failures++;
		end

	assert property (@(posedge clk) $rose(rst_n) |-> !busy)
		else
		begin
			$error("busy high when reset is released");
			failures++;
		end

	// every output pulse traces back to an accept
	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(instr_valid && !busy))
		else
		begin
			$error("out_valid without an accept one cycle earlier");
			failures++;
		end

	// longest stall is the writeback one
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(busy) |-> ##[1:`WB_STALL_CYCLES] !busy)
		else
		begin
			$error("busy held longer than the writeback stall");
			failures++;
		end

endmodule

bind decode_stage decode_stage_assertions i_assertions
(
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.busy        (busy),
	.out_valid   (out_valid)
);

// ==== tests/decode_stage_tb.sv ====
`timescale 1ns/1ps

`include "decode_cfg.svh"

module decode_stage_tb
	import decode_pkg::*;
();

	localparam int period = 100;
	// reset, then alu, ctrl, mem, undefined, operands, back-pressure
	localparam int run_cycles = 8 + 32 + 20 + 160 + 8 + 42 + 12;

	logic                      clk;
	logic                      rst_n;
	logic                      instr_valid;
	logic [`INSTR_WIDTH-1:0]   instr;
	logic                      wr_en;
	logic [`REG_IDX_WIDTH-1:0] wr_index;
	logic [`DATA_WIDTH-1:0]    wr_data;
	logic                      busy;
	logic                      out_valid;
	instr_group_e              out_group;
	logic [`OPER_WIDTH-1:0]    out_oper;
	logic                      out_op_type;
	logic [`REG_IDX_WIDTH-1:0] out_ra_index;
	logic [`REG_IDX_WIDTH-1:0] out_rb_index;
	logic [`REG_IDX_WIDTH-1:0] out_rc_index;
	logic [`DATA_WIDTH-1:0]    out_ra_data;
	logic [`DATA_WIDTH-1:0]    out_rb_data;
	logic [`DATA_WIDTH-1:0]    out_rc_data;
	logic [`DATA_WIDTH-1:0]    out_imm;
	logic                      out_nop;
	logic                      out_force64;
	stall_class_e              out_stall_class;

	integer                 seed = 32'h7d7c_5a23;
	int                     errors;
	int                     checks;
	logic [`DATA_WIDTH-1:0] shadow [`REG_COUNT];

	// expected fields from the reference model
	logic [2:0]             exp_group;
	logic [3:0]             exp_oper;
	logic                   exp_op_type;
	logic [`DATA_WIDTH-1:0] exp_imm;
	logic                   exp_nop;
	logic                   exp_force64;
	logic [1:0]             exp_stall;
	int                     exp_busy_len;

	decode_stage i_dut (.*);

	initial clk = 1'b0;
	always #(period / 2) clk = ~clk;

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic model_decode(input logic [31:0] w);
		exp_group   = w[31:29];
		exp_op_type = w[12];
		exp_oper    = w[16:13];
		exp_imm     = {{52{w[11]}}, w[11:0]};
		exp_nop     = 1'b0;
		exp_stall   = stall_none;
		case (w[31:29])
			3'd0:
			begin
				exp_nop = (exp_oper == bad_alu);
			end
			3'd1:
			begin
				// control words carry oper in the rb slot and a 20 bit offset
				exp_oper  = w[24:21];
				exp_imm   = {{44{w[20]}}, w[20:1]};
				exp_nop   = (exp_oper > jmp);
				exp_stall = stall_ends_in_ex;
			end
			3'd2, 3'd3:
			begin
				exp_nop   = (exp_oper > f16);
				exp_stall = stall_ends_in_wb;
			end
			default:
			begin
				exp_oper = '0;
				exp_imm  = '0;
				exp_nop  = 1'b1;
			end
		endcase
		exp_force64 = (w[31:29] == 3'd0) && ((exp_oper == div) || (exp_oper == shl)
			|| (exp_oper == shr) || (exp_oper == inv));
		exp_busy_len = exp_nop ? 0 : (exp_stall == stall_ends_in_ex) ? `EX_STALL_CYCLES
			: (exp_stall == stall_ends_in_wb) ? `WB_STALL_CYCLES : 0;
	endtask

	// present one word with an optional same-cycle register write
	task automatic issue(input logic [31:0] w, input logic do_write, input logic [3:0] w_idx,
		input logic [63:0] w_data);
		logic [63:0] exp_ra;
		logic [63:0] exp_rb;
		logic [63:0] exp_rc;
		int          busy_len;
		model_decode(w);
		exp_ra = (do_write && (w_idx == w[28:25])) ? w_data : shadow[w[28:25]];
		exp_rb = (do_write && (w_idx == w[24:21])) ? w_data : shadow[w[24:21]];
		exp_rc = (do_write && (w_idx == w[20:17])) ? w_data : shadow[w[20:17]];
		@(negedge clk);
		instr_valid = 1'b1;
		instr       = w;
		wr_en       = do_write;
		wr_index    = w_idx;
		wr_data     = w_data;
		@(negedge clk);
		instr_valid = 1'b0;
		wr_en       = 1'b0;
		if (do_write)
			shadow[w_idx] = w_data;
		check(out_valid, 1'b1, "out_valid");
		check(out_group, exp_group, "group");
		check(out_oper, exp_oper, "oper");
		check(out_op_type, exp_op_type, "op_type");
		check(out_ra_index, w[28:25], "ra index");
		check(out_rb_index, w[24:21], "rb index");
		check(out_rc_index, w[20:17], "rc index");
		check(out_ra_data, exp_ra, "ra data");
		check(out_rb_data, exp_rb, "rb data");
		check(out_rc_data, exp_rc, "rc data");
		check(out_imm, exp_imm, "immediate");
		check(out_nop, exp_nop, "nop");
		check(out_force64, exp_force64, "force64");
		check(out_stall_class, exp_stall, "stall class");
		busy_len = 0;
		while (busy && (busy_len < 8))
		begin
			busy_len++;
			@(negedge clk);
		end
		check(busy_len, exp_busy_len, "busy length");
	endtask

	task automatic write_reg(input logic [3:0] idx, input logic [63:0] data);
		@(negedge clk);
		wr_en    = 1'b1;
		wr_index = idx;
		wr_data  = data;
		shadow[idx] = data;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic test_alu();
		int          start_errors;
		logic [31:0] w;
		start_errors = errors;
		for (int op = 0; op < 16; op++)
		begin
			w = $random(seed);
			w[31:29] = alu_grp;
			w[16:13] = op[3:0];
			// alternate the immediate sign
			w[11] = op[0];
			issue(w, 1'b0, 4'd0, 64'd0);
		end
		$display("alu group test finished, %0d errors", errors - start_errors);
	endtask

	task automatic test_ctrl();
		int          start_errors;
		logic [31:0] w;
		start_errors = errors;
		// btru, bfal, jmp, then two reserved codes
		for (int op = 0; op < 5; op++)
		begin
			w = $random(seed);
			w[31:29] = ctrl_grp;
			w[24:21] = (op == 4) ? 4'd15 : op[3:0];
			w[20] = op[0];
			issue(w, 1'b0, 4'd0, 64'd0);
		end
		$display("control group test finished, %0d errors", errors - start_errors);
	endtask

	task automatic test_mem();
		int          start_errors;
		logic [31:0] w;
		start_errors = errors;
		for (int grp = 2; grp < 4; grp++)
		begin
			for (int op = 0; op < 16; op++)
			begin
				w = $random(seed);
				w[31:29] = grp[2:0];
				w[16:13] = op[3:0];
				issue(w, 1'b0, 4'd0, 64'd0);
			end
		end
		$display("load and store test finished, %0d errors", errors - start_errors);
	endtask

	task automatic test_undefined();
		int          start_errors;
		logic [31:0] w;
		start_errors = errors;
		for (int grp = 4; grp < 8; grp++)
		begin
			w = $random(seed);
			w[31:29] = grp[2:0];
			issue(w, 1'b0, 4'd0, 64'd0);
		end
		$display("undefined group test finished, %0d errors", errors - start_errors);
	endtask

	task automatic test_operands();
		int          start_errors;
		logic [31:0] w;
		start_errors = errors;
		for (int i = 0; i < `REG_COUNT; i++)
			write_reg(i[3:0], {$random(seed), $random(seed)});
		for (int k = 0; k < 4; k++)
		begin
			w = $random(seed);
			w[31:29] = alu_grp;
			w[16:13] = add;
			issue(w, 1'b0, 4'd0, 64'd0);
		end
		// ra and rb share an index that is written in the accept cycle
		w = $random(seed);
		w[31:29] = alu_grp;
		w[16:13] = add;
		w[24:21] = w[28:25];
		issue(w, 1'b1, w[28:25], {$random(seed), $random(seed)});
		$display("register operand test finished, %0d errors", errors - start_errors);
	endtask

	task automatic test_backpressure();
		int          start_errors;
		int          waited;
		logic [31:0] w;
		logic [31:0] blocked;
		start_errors = errors;
		w = $random(seed);
		w[31:29] = store_grp;
		w[16:13] = u64;
		blocked = $random(seed);
		blocked[31:29] = load_grp;
		blocked[16:13] = s32;
		@(negedge clk);
		instr_valid = 1'b1;
		instr       = w;
		@(negedge clk);
		check(busy, 1'b1, "busy after store");
		instr = blocked;
		@(negedge clk);
		instr_valid = 1'b0;
		waited = 0;
		while (busy && (waited < 8))
		begin
			check(out_valid, 1'b0, "out_valid while busy");
			waited++;
			@(negedge clk);
		end
		// a dropped load would have reloaded the stall counter
		check(waited + 1, `WB_STALL_CYCLES, "store busy length");
		issue(blocked, 1'b0, 4'd0, 64'd0);
		$display("back-pressure test finished, %0d errors", errors - start_errors);
	endtask

	initial
	begin
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		wr_en       = 1'b0;
		wr_index    = '0;
		wr_data     = '0;
		errors      = 0;
		checks      = 0;
		for (int i = 0; i < `REG_COUNT; i++)
			shadow[i] = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		test_alu();
		test_ctrl();
		test_mem();
		test_undefined();
		test_operands();
		test_backpressure();
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			i_dut.i_assertions.failures);
		if ((errors == 0) && (i_dut.i_assertions.failures == 0))
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		#(run_cycles * 2 * period);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/stall_unit.sv
verilog/decode_stage.sv
tests/decode_stage_assertions.sv
tests/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/decode_pkg.sv
      - verilog/instr_decoder.sv
      - verilog/reg_file.sv
      - verilog/stall_unit.sv
      - verilog/decode_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/decode_stage_assertions.sv
      - tests/decode_stage_tb.sv
